// ==== Makefile ====
# Verilator build, run and lint for the rename core

VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= rename_tb
RTL_TOP   ?= rename_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TB_TOP)

run: build
	out=$$(./$(OBJ_DIR)/V$(TB_TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+rtl
rtl/rename_pkg.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/reorder_buffer.sv
rtl/rename_stage.sv
rtl/rename_core.sv
verification/rename_tb.sv

// ==== rtl/free_list.sv ====
// Physical register free list

`timescale 1ns/100ps

`include "rename_cfg.svh"

module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // Allocation at dispatch
    input  logic      alloc_req_i,
    output phys_reg_t alloc_phys_o,
    output logic      free_empty_o,
    // Release at retirement
    input  logic      release_valid_i,
    input  phys_reg_t release_phys_i
);

    // Registers beyond the initial identity map
    localparam int FL_DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W    = $clog2(FL_DEPTH);
    localparam int CNT_W    = $clog2(FL_DEPTH + 1);

    phys_reg_t          fifo_q [FL_DEPTH];
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [CNT_W-1:0]   count_q;

    // Head of the FIFO is the next tag out
    assign alloc_phys_o = fifo_q[rd_ptr_q];
    assign free_empty_o = (count_q == '0);

    //////////////////////////////////////////////////////////////////////
    // FIFO state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Preload ARCH_REGS..PHYS_REGS-1 ascending, list full
            for (int i = 0; i < FL_DEPTH; i++) begin
                fifo_q[i] <= phys_reg_t'(`ARCH_REGS + i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= CNT_W'(FL_DEPTH);
        end else begin
            // Freed tag goes behind everything already queued
            if (release_valid_i) begin
                fifo_q[wr_ptr_q] <= release_phys_i;
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FL_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (alloc_req_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FL_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Both at once leaves the count alone
            if (release_valid_i && !alloc_req_i) begin
                count_q <= count_q + 1'b1;
            end else if (alloc_req_i && !release_valid_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/map_table.sv ====
// Speculative register map table

`timescale 1ns/100ps

`include "rename_cfg.svh"

module map_table import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // Source lookups
    input  arch_reg_t src1_arch_i,
    input  arch_reg_t src2_arch_i,
    output phys_reg_t src1_phys_o,
    output phys_reg_t src2_phys_o,
    output logic      src1_ready_o,
    output logic      src2_ready_o,
    // Destination rename
    input  logic      rename_fire_i,
    input  arch_reg_t rename_arch_i,
    input  phys_reg_t rename_phys_i,
    output phys_reg_t old_phys_o,
    // Completion wakeup
    input  logic      wakeup_valid_i,
    input  phys_reg_t wakeup_phys_i
);

    // One tag and one ready bit per architectural register
    phys_reg_t              map_q [`ARCH_REGS];
    logic [`ARCH_REGS-1:0]  ready_q;

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    assign src1_phys_o = map_q[src1_arch_i];
    assign src2_phys_o = map_q[src2_arch_i];

    // Bypass a wakeup landing this cycle so it is not lost
    assign src1_ready_o = ready_q[src1_arch_i]
                        | (wakeup_valid_i && (wakeup_phys_i == map_q[src1_arch_i]));
    assign src2_ready_o = ready_q[src2_arch_i]
                        | (wakeup_valid_i && (wakeup_phys_i == map_q[src2_arch_i]));

    // Mapping being replaced, handed to the ROB
    assign old_phys_o = map_q[rename_arch_i];

    //////////////////////////////////////////////////////////////////////
    // Update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, everything ready
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i]   <= phys_reg_t'(i);
                ready_q[i] <= 1'b1;
            end
        end else begin
            // Wakeup only hits an entry still holding that tag
            if (wakeup_valid_i) begin
                for (int i = 0; i < `ARCH_REGS; i++) begin
                    if (map_q[i] == wakeup_phys_i) begin
                        ready_q[i] <= 1'b1;
                    end
                end
            end
            // Rename last so it wins on its own entry
            if (rename_fire_i) begin
                map_q[rename_arch_i]   <= rename_phys_i;
                ready_q[rename_arch_i] <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/rename_cfg.svh ====
// Rename core configuration

`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Register file sizes
//////////////////////////////////////////////////////////////////////

// Architectural registers seen by software
`define ARCH_REGS 8

// Physical registers behind the rename map
// Must exceed ARCH_REGS, the surplus feeds the free list
`define PHYS_REGS 16

//////////////////////////////////////////////////////////////////////
// Reorder buffer
//////////////////////////////////////////////////////////////////////

// In-flight instruction slots
`define ROB_DEPTH 8

`endif

// ==== rtl/rename_core.sv ====
// Register rename core top level

`timescale 1ns/100ps

module rename_core import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // Dispatch
    input  logic      disp_valid_i,
    input  logic      disp_has_dest_i,
    input  arch_reg_t disp_dest_arch_i,
    input  arch_reg_t disp_src1_arch_i,
    input  arch_reg_t disp_src2_arch_i,
    output logic      disp_ready_o,
    // Rename result
    output logic      ren_valid_o,
    output phys_reg_t ren_src1_phys_o,
    output phys_reg_t ren_src2_phys_o,
    output logic      ren_src1_ready_o,
    output logic      ren_src2_ready_o,
    output phys_reg_t ren_dest_phys_o,
    output phys_reg_t ren_old_phys_o,
    output rob_idx_t  ren_rob_idx_o,
    // Completion
    input  logic      complete_valid_i,
    input  rob_idx_t  complete_rob_idx_i,
    // Commit
    output logic      commit_valid_o,
    output logic      commit_has_dest_o,
    output arch_reg_t commit_dest_arch_o,
    output phys_reg_t commit_new_phys_o,
    output phys_reg_t commit_freed_phys_o
);

    //////////////////////////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////////////////////////

    // Dispatch strobes
    logic      disp_fire;
    logic      rename_fire;
    logic      alloc_req;
    // Map table lookups
    phys_reg_t src1_phys;
    phys_reg_t src2_phys;
    logic      src1_ready;
    logic      src2_ready;
    phys_reg_t old_phys;
    // Free list
    phys_reg_t alloc_phys;
    logic      free_empty;
    // ROB status and feedback
    logic      rob_full;
    rob_idx_t  tail_idx;
    logic      wakeup_valid;
    phys_reg_t wakeup_phys;
    logic      release_valid;

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////

    rename_stage i_rename_stage (
        .clock            (clock),
        .reset            (reset),
        .disp_valid_i     (disp_valid_i),
        .disp_has_dest_i  (disp_has_dest_i),
        .disp_dest_arch_i (disp_dest_arch_i),
        .disp_ready_o     (disp_ready_o),
        .src1_phys_i      (src1_phys),
        .src2_phys_i      (src2_phys),
        .src1_ready_i     (src1_ready),
        .src2_ready_i     (src2_ready),
        .old_phys_i       (old_phys),
        .alloc_phys_i     (alloc_phys),
        .free_empty_i     (free_empty),
        .rob_full_i       (rob_full),
        .tail_idx_i       (tail_idx),
        .disp_fire_o      (disp_fire),
        .rename_fire_o    (rename_fire),
        .alloc_req_o      (alloc_req),
        .ren_valid_o      (ren_valid_o),
        .ren_src1_phys_o  (ren_src1_phys_o),
        .ren_src2_phys_o  (ren_src2_phys_o),
        .ren_src1_ready_o (ren_src1_ready_o),
        .ren_src2_ready_o (ren_src2_ready_o),
        .ren_dest_phys_o  (ren_dest_phys_o),
        .ren_old_phys_o   (ren_old_phys_o),
        .ren_rob_idx_o    (ren_rob_idx_o)
    );

    // Source numbers bypass the stage straight into the map
    map_table i_map_table (
        .clock          (clock),
        .reset          (reset),
        .src1_arch_i    (disp_src1_arch_i),
        .src2_arch_i    (disp_src2_arch_i),
        .src1_phys_o    (src1_phys),
        .src2_phys_o    (src2_phys),
        .src1_ready_o   (src1_ready),
        .src2_ready_o   (src2_ready),
        .rename_fire_i  (rename_fire),
        .rename_arch_i  (disp_dest_arch_i),
        .rename_phys_i  (alloc_phys),
        .old_phys_o     (old_phys),
        .wakeup_valid_i (wakeup_valid),
        .wakeup_phys_i  (wakeup_phys)
    );

    free_list i_free_list (
        .clock           (clock),
        .reset           (reset),
        .alloc_req_i     (alloc_req),
        .alloc_phys_o    (alloc_phys),
        .free_empty_o    (free_empty),
        .release_valid_i (release_valid),
        .release_phys_i  (commit_freed_phys_o)
    );

    // Released tag doubles as the commit's freed register
    reorder_buffer i_reorder_buffer (
        .clock              (clock),
        .reset              (reset),
        .disp_fire_i        (disp_fire),
        .disp_has_dest_i    (disp_has_dest_i),
        .disp_arch_i        (disp_dest_arch_i),
        .disp_new_phys_i    (alloc_phys),
        .disp_old_phys_i    (old_phys),
        .rob_full_o         (rob_full),
        .tail_idx_o         (tail_idx),
        .complete_valid_i   (complete_valid_i),
        .complete_rob_idx_i (complete_rob_idx_i),
        .wakeup_valid_o     (wakeup_valid),
        .wakeup_phys_o      (wakeup_phys),
        .commit_valid_o     (commit_valid_o),
        .commit_has_dest_o  (commit_has_dest_o),
        .commit_dest_arch_o (commit_dest_arch_o),
        .commit_new_phys_o  (commit_new_phys_o),
        .release_valid_o    (release_valid),
        .release_phys_o     (commit_freed_phys_o)
    );

endmodule

// ==== rtl/rename_pkg.sv ====
// Rename core shared types

`include "rename_cfg.svh"

package rename_pkg;

    // Architectural register number
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // Physical register tag
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

    // Reorder buffer slot index
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // Lifecycle of one reorder buffer slot
    typedef enum logic [1:0] {
        // Slot unused
        ROB_FREE = 2'd0,
        // Dispatched, waiting on completion
        ROB_BUSY = 2'd1,
        // Completed, waiting to retire
        ROB_DONE = 2'd2
    } rob_state_e;

endpackage

// ==== rtl/rename_stage.sv ====
// Dispatch accept and rename register

`timescale 1ns/100ps

module rename_stage import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // Dispatch handshake
    input  logic      disp_valid_i,
    input  logic      disp_has_dest_i,
    input  arch_reg_t disp_dest_arch_i,
    output logic      disp_ready_o,
    // From map table
    input  phys_reg_t src1_phys_i,
    input  phys_reg_t src2_phys_i,
    input  logic      src1_ready_i,
    input  logic      src2_ready_i,
    input  phys_reg_t old_phys_i,
    // From free list and ROB
    input  phys_reg_t alloc_phys_i,
    input  logic      free_empty_i,
    input  logic      rob_full_i,
    input  rob_idx_t  tail_idx_i,
    // Strobes
    output logic      disp_fire_o,
    output logic      rename_fire_o,
    output logic      alloc_req_o,
    // Registered rename result
    output logic      ren_valid_o,
    output phys_reg_t ren_src1_phys_o,
    output phys_reg_t ren_src2_phys_o,
    output logic      ren_src1_ready_o,
    output logic      ren_src2_ready_o,
    output phys_reg_t ren_dest_phys_o,
    output phys_reg_t ren_old_phys_o,
    output rob_idx_t  ren_rob_idx_o
);

    logic      accept;

    //////////////////////////////////////////////////////////////////////
    // Accept
    //////////////////////////////////////////////////////////////////////

    // Same test with or without a destination
    assign disp_ready_o = !rob_full_i && !free_empty_i;
    assign accept       = disp_valid_i && disp_ready_o;

    assign disp_fire_o   = accept;
    // Tag and map only for a real destination
    assign rename_fire_o = accept && disp_has_dest_i;
    assign alloc_req_o   = accept && disp_has_dest_i;

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ren_valid_o <= 1'b0;
        end else begin
            ren_valid_o <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            ren_src1_phys_o  <= src1_phys_i;
            ren_src2_phys_o  <= src2_phys_i;
            ren_src1_ready_o <= src1_ready_i;
            ren_src2_ready_o <= src2_ready_i;
            ren_rob_idx_o    <= tail_idx_i;
            // Zero tags when nothing is written
            ren_dest_phys_o  <= disp_has_dest_i ? alloc_phys_i : '0;
            ren_old_phys_o   <= disp_has_dest_i ? old_phys_i : '0;
        end
    end

endmodule

// ==== rtl/reorder_buffer.sv ====
// In-order retirement buffer

`timescale 1ns/100ps

`include "rename_cfg.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // Dispatch into the tail
    input  logic      disp_fire_i,
    input  logic      disp_has_dest_i,
    input  arch_reg_t disp_arch_i,
    input  phys_reg_t disp_new_phys_i,
    input  phys_reg_t disp_old_phys_i,
    output logic      rob_full_o,
    output rob_idx_t  tail_idx_o,
    // Completion by slot index
    input  logic      complete_valid_i,
    input  rob_idx_t  complete_rob_idx_i,
    output logic      wakeup_valid_o,
    output phys_reg_t wakeup_phys_o,
    // Retirement from the head
    output logic      commit_valid_o,
    output logic      commit_has_dest_o,
    output arch_reg_t commit_dest_arch_o,
    output phys_reg_t commit_new_phys_o,
    output logic      release_valid_o,
    output phys_reg_t release_phys_o
);

    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    // Control per slot
    rob_state_e       state_q [`ROB_DEPTH];
    rob_idx_t         head_q;
    rob_idx_t         tail_q;
    logic [CNT_W-1:0] count_q;

    // Payload per slot
    logic             has_dest_q [`ROB_DEPTH];
    arch_reg_t        arch_q     [`ROB_DEPTH];
    phys_reg_t        new_phys_q [`ROB_DEPTH];
    phys_reg_t        old_phys_q [`ROB_DEPTH];

    logic             complete_hit;

    //////////////////////////////////////////////////////////////////////
    // Status and outputs
    //////////////////////////////////////////////////////////////////////

    assign rob_full_o = (count_q == CNT_W'(`ROB_DEPTH));
    assign tail_idx_o = tail_q;

    // Stray completions on non-busy slots are dropped
    assign complete_hit = complete_valid_i && (state_q[complete_rob_idx_i] == ROB_BUSY);

    // No wakeup for an instruction that writes nothing
    assign wakeup_valid_o = complete_hit && has_dest_q[complete_rob_idx_i];
    assign wakeup_phys_o  = new_phys_q[complete_rob_idx_i];

    // Head retires whenever it has completed
    assign commit_valid_o     = (state_q[head_q] == ROB_DONE);
    assign commit_has_dest_o  = has_dest_q[head_q];
    assign commit_dest_arch_o = arch_q[head_q];
    assign commit_new_phys_o  = new_phys_q[head_q];

    // Previous mapping goes back to the free list
    assign release_valid_o = commit_valid_o && has_dest_q[head_q];
    assign release_phys_o  = old_phys_q[head_q];

    //////////////////////////////////////////////////////////////////////
    // Slot state and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ROB_FREE;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (disp_fire_i) begin
                state_q[tail_q] <= ROB_BUSY;
                tail_q <= (tail_q == rob_idx_t'(`ROB_DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            if (complete_hit) begin
                state_q[complete_rob_idx_i] <= ROB_DONE;
            end
            if (commit_valid_o) begin
                state_q[head_q] <= ROB_FREE;
                head_q <= (head_q == rob_idx_t'(`ROB_DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            // Occupancy
            if (disp_fire_i && !commit_valid_o) begin
                count_q <= count_q + 1'b1;
            end else if (commit_valid_o && !disp_fire_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Destination fields captured at the tail, zero tags when none
    always_ff @(posedge clock) begin
        if (disp_fire_i) begin
            has_dest_q[tail_q] <= disp_has_dest_i;
            arch_q[tail_q]     <= disp_arch_i;
            new_phys_q[tail_q] <= disp_has_dest_i ? disp_new_phys_i : '0;
            old_phys_q[tail_q] <= disp_has_dest_i ? disp_old_phys_i : '0;
        end
    end

endmodule

// ==== verification/rename_cases.txt ====
// One 12-digit hex word per case, one field per digit, left to right
// dispatch: 1 has_dest dest src1 src2 | exp src1 tag, rdy, src2 tag, rdy, dest, old, rob
// complete: 2 rob commit_expected | exp has_dest arch new freed, then zeros
// 3 exp_ready after one cycle, 4 next commit in the following cycle, 0 ends the list

// Identity map after reset, dependent sources
111232131810
112148041921
113219080a32
// Out of order completion, in order commit
220000000000
201118100000
1141381a1b43
211129200000
40113a300000

// Instruction without a destination
10540b001004
115525191c55
240000000000
23114b400000
401000000000
25115c500000

// Fill the ROB, back-pressure, freed tags reused in order
116070171d66
11765d0c1e77
11071e081f00
10002f091001
11134a1b1182
1121610d0293
1132220203a4
11453c1304b5
300000000000
26116d600000
310000000000
11560d1f05c6
27117e700000
1165750e16d7

000000000000

// ==== verification/rename_tb.sv ====
// Rename core testbench

`timescale 1ns/100ps

module rename_tb import rename_pkg::*; ();

    localparam int MAX_CASES      = 64;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int SEED           = 55875;

    logic      clock;
    logic      reset;
    // Dispatch and completion inputs
    logic      disp_valid_i;
    logic      disp_has_dest_i;
    arch_reg_t disp_dest_arch_i;
    arch_reg_t disp_src1_arch_i;
    arch_reg_t disp_src2_arch_i;
    logic      complete_valid_i;
    rob_idx_t  complete_rob_idx_i;
    // Outputs under test
    logic      disp_ready_o;
    logic      ren_valid_o;
    phys_reg_t ren_src1_phys_o;
    phys_reg_t ren_src2_phys_o;
    logic      ren_src1_ready_o;
    logic      ren_src2_ready_o;
    phys_reg_t ren_dest_phys_o;
    phys_reg_t ren_old_phys_o;
    rob_idx_t  ren_rob_idx_o;
    logic      commit_valid_o;
    logic      commit_has_dest_o;
    arch_reg_t commit_dest_arch_o;
    phys_reg_t commit_new_phys_o;
    phys_reg_t commit_freed_phys_o;

    // Case words, current word split into hex digits
    logic [47:0] case_mem [MAX_CASES];
    logic [3:0]  fld [12];
    int          cases_run;

    rename_core i_dut (
        .clock               (clock),
        .reset               (reset),
        .disp_valid_i        (disp_valid_i),
        .disp_has_dest_i     (disp_has_dest_i),
        .disp_dest_arch_i    (disp_dest_arch_i),
        .disp_src1_arch_i    (disp_src1_arch_i),
        .disp_src2_arch_i    (disp_src2_arch_i),
        .disp_ready_o        (disp_ready_o),
        .ren_valid_o         (ren_valid_o),
        .ren_src1_phys_o     (ren_src1_phys_o),
        .ren_src2_phys_o     (ren_src2_phys_o),
        .ren_src1_ready_o    (ren_src1_ready_o),
        .ren_src2_ready_o    (ren_src2_ready_o),
        .ren_dest_phys_o     (ren_dest_phys_o),
        .ren_old_phys_o      (ren_old_phys_o),
        .ren_rob_idx_o       (ren_rob_idx_o),
        .complete_valid_i    (complete_valid_i),
        .complete_rob_idx_i  (complete_rob_idx_i),
        .commit_valid_o      (commit_valid_o),
        .commit_has_dest_o   (commit_has_dest_o),
        .commit_dest_arch_o  (commit_dest_arch_o),
        .commit_new_phys_o   (commit_new_phys_o),
        .commit_freed_phys_o (commit_freed_phys_o)
    );

    // 8 ns period
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [3:0] actual,
                               input logic [3:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s actual 0x%0h expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Cycle helpers
    //////////////////////////////////////////////////////////////////////

    // One clock of a bounded wait, inputs move 1 ns past the edge
    task automatic step_cycle(input string what, inout int waited);
        if (waited >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timed out waiting for %s", what));
        end else begin
            @(posedge clock);
            #1;
            waited++;
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 3;
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Case handlers
    //////////////////////////////////////////////////////////////////////

    task automatic run_dispatch();
        int n;
        disp_valid_i     = 1'b1;
        disp_has_dest_i  = fld[10][0];
        disp_dest_arch_i = arch_reg_t'(fld[9]);
        disp_src1_arch_i = arch_reg_t'(fld[8]);
        disp_src2_arch_i = arch_reg_t'(fld[7]);
        // Hold the instruction through back-pressure
        n = 0;
        while (!disp_ready_o) step_cycle("disp_ready_o", n);
        @(posedge clock);
        #1;
        disp_valid_i = 1'b0;
        n = 0;
        while (!ren_valid_o) step_cycle("ren_valid_o", n);
        check_value("ren_src1_phys_o", 4'(ren_src1_phys_o), fld[6]);
        check_value("ren_src1_ready_o", 4'(ren_src1_ready_o), fld[5]);
        check_value("ren_src2_phys_o", 4'(ren_src2_phys_o), fld[4]);
        check_value("ren_src2_ready_o", 4'(ren_src2_ready_o), fld[3]);
        check_value("ren_dest_phys_o", 4'(ren_dest_phys_o), fld[2]);
        check_value("ren_old_phys_o", 4'(ren_old_phys_o), fld[1]);
        check_value("ren_rob_idx_o", 4'(ren_rob_idx_o), fld[0]);
    endtask

    // Register fields only mean something when the entry writes one
    task automatic check_commit();
        check_value("commit_has_dest_o", 4'(commit_has_dest_o), fld[8]);
        if (fld[8][0]) begin
            check_value("commit_dest_arch_o", 4'(commit_dest_arch_o), fld[7]);
            check_value("commit_new_phys_o", 4'(commit_new_phys_o), fld[6]);
            check_value("commit_freed_phys_o", 4'(commit_freed_phys_o), fld[5]);
        end
    endtask

    task automatic run_completion();
        int n;
        complete_valid_i   = 1'b1;
        complete_rob_idx_i = rob_idx_t'(fld[10]);
        @(posedge clock);
        #1;
        complete_valid_i = 1'b0;
        if (fld[9][0]) begin
            n = 0;
            while (!commit_valid_o) step_cycle("commit_valid_o", n);
            check_commit();
        end else begin
            // Head still busy
            check_value("commit_valid_o", 4'(commit_valid_o), 4'h0);
        end
    endtask

    // Next retirement in the cycle after the previous one
    task automatic run_commit_only();
        int n;
        @(posedge clock);
        #1;
        n = 0;
        while (!commit_valid_o) step_cycle("commit_valid_o", n);
        check_commit();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int  idx;
        bit  finished;
        void'($urandom(SEED));
        reset              = 1'b1;
        disp_valid_i       = 1'b0;
        disp_has_dest_i    = 1'b0;
        disp_dest_arch_i   = '0;
        disp_src1_arch_i   = '0;
        disp_src2_arch_i   = '0;
        complete_valid_i   = 1'b0;
        complete_rob_idx_i = '0;
        cases_run          = 0;
        $readmemh("verification/rename_cases.txt", case_mem);
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        // Quiet pipeline, room to dispatch
        check_value("ren_valid_o", 4'(ren_valid_o), 4'h0);
        check_value("commit_valid_o", 4'(commit_valid_o), 4'h0);
        check_value("disp_ready_o", 4'(disp_ready_o), 4'h1);
        idx      = 0;
        finished = 1'b0;
        while (!finished && idx < MAX_CASES) begin
            for (int i = 0; i < 12; i++) begin
                fld[i] = case_mem[idx][i*4 +: 4];
            end
            case (fld[11])
                4'h1: begin
                    idle_gap();
                    run_dispatch();
                end
                4'h2: begin
                    idle_gap();
                    run_completion();
                end
                4'h3: begin
                    @(posedge clock);
                    #1;
                    check_value("disp_ready_o", 4'(disp_ready_o), fld[10]);
                end
                4'h4: run_commit_only();
                default: finished = 1'b1;
            endcase
            if (!finished) begin
                cases_run++;
            end
            idx++;
        end
        if (cases_run > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("No cases were read from verification/rename_cases.txt");
        end
    end

endmodule
